/* include/sys_config.svh */
`ifndef SYS_CONFIG_SVH
`define SYS_CONFIG_SVH

// Data and address width of the core.
`define XLEN 32

// Queue entries. The issue stage starts with this many credits.
`define SYS_QUEUE_DEPTH 4

// Machine CSR addresses handled by the unit.
`define CSR_MSTATUS 12'h300
`define CSR_MTVEC   12'h305
`define CSR_MEPC    12'h341
`define CSR_MCAUSE  12'h342

`endif

/* rtl/sys_pkg.sv */
`include "sys_config.svh"

package sys_pkg;

    // One data or address word.
    typedef logic [`XLEN-1:0] xlen_t;

    // Raw instruction word from the issue stage.
    typedef logic [31:0] inst_t;

    // CSR address field of a SYSTEM instruction.
    typedef logic [11:0] csr_addr_t;

    // Operation carried from the decoder to the CSR file.
    // The immediate forms share the three CSR codes, the zimm comes in the operand.
    typedef enum logic [2:0] {
        OP_CSRRW = 3'd0,
        OP_CSRRS = 3'd1,
        OP_CSRRC = 3'd2,
        OP_ECALL = 3'd3,
        OP_MRET  = 3'd4,
        OP_NONE  = 3'd5 // Anything else. Answered without effect.
    } sys_op_e;

endpackage

/* rtl/sys_req_if.sv */
// Instruction handed from the queue head to the decoder.
interface sys_req_if;
    logic           valid;
    sys_pkg::inst_t inst;
    sys_pkg::xlen_t pc;
    sys_pkg::xlen_t rs1_data;
    logic           ready;

    modport source (
        output valid, inst, pc, rs1_data,
        input  ready
    );

    modport sink (
        input  valid, inst, pc, rs1_data,
        output ready
    );
endinterface

// Decoded operation handed to the CSR file.
interface sys_op_if;
    logic               valid;
    sys_pkg::sys_op_e   op;
    sys_pkg::csr_addr_t csr_addr;
    sys_pkg::xlen_t     operand;
    logic               write_en; // Low for csrrs/csrrc with a zero rs1 field.
    sys_pkg::xlen_t     pc;

    modport source (
        output valid, op, csr_addr, operand, write_en, pc
    );

    modport sink (
        input  valid, op, csr_addr, operand, write_en, pc
    );
endinterface

/* rtl/sys_inst_queue.sv */
`include "sys_config.svh"

module sys_inst_queue (
    input  logic           clk,
    input  logic           reset,
    input  logic           i_valid,
    input  sys_pkg::inst_t i_inst,
    input  sys_pkg::xlen_t i_pc,
    input  sys_pkg::xlen_t i_rs1_data,
    output logic           o_credit_return,
    sys_req_if.source      o_req
);

    localparam int DEPTH = `SYS_QUEUE_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    sys_pkg::inst_t   inst_mem [DEPTH];
    sys_pkg::xlen_t   pc_mem   [DEPTH];
    sys_pkg::xlen_t   rs1_mem  [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;
    logic             empty;
    logic             full;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty = (count == '0);
    assign full  = (count == CNT_W'(DEPTH));
    assign push  = i_valid; // The sender only asks while it holds a credit.
    assign pop   = !empty && o_req.ready;

    // Each entry leaving the queue frees one slot at the sender.
    assign o_credit_return = pop;

    assign o_req.valid    = !empty;
    assign o_req.inst     = inst_mem[rd_ptr];
    assign o_req.pc       = pc_mem[rd_ptr];
    assign o_req.rs1_data = rs1_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            inst_mem[wr_ptr] <= i_inst;
            pc_mem[wr_ptr]   <= i_pc;
            rs1_mem[wr_ptr]  <= i_rs1_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= next_ptr(wr_ptr);
            if (pop) rd_ptr <= next_ptr(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // A push into a full queue means the sender spent a credit it never had.
    a_no_push_when_full: assert property (@(posedge clk) disable iff (reset)
        i_valid |-> !full);

    // A credit goes back only while the pointers show a stored entry.
    a_no_credit_when_empty: assert property (@(posedge clk) disable iff (reset)
        o_credit_return |-> ((wr_ptr != rd_ptr) || full) && !$isunknown(o_req.inst));

endmodule

/* rtl/sys_decode.sv */
module sys_decode (
    input  logic     clk,
    input  logic     reset,
    sys_req_if.sink  i_req,
    sys_op_if.source o_op
);

    localparam logic [6:0]  OPCODE_SYSTEM = 7'b1110011;
    localparam logic [11:0] FUNCT12_ECALL = 12'h000;
    localparam logic [11:0] FUNCT12_MRET  = 12'h302;

    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [4:0]       rs1_field;
    logic [11:0]      funct12;
    sys_pkg::sys_op_e op_d;
    sys_pkg::xlen_t   operand_d;
    logic             write_en_d;

    assign opcode    = i_req.inst[6:0];
    assign funct3    = i_req.inst[14:12];
    assign rs1_field = i_req.inst[19:15]; // Also the zimm of the immediate forms.
    assign funct12   = i_req.inst[31:20];

    // The CSR file takes one op per cycle, so the decoder never stalls.
    assign i_req.ready = 1'b1;

    always_comb begin
        op_d = sys_pkg::OP_NONE;
        if (opcode == OPCODE_SYSTEM) begin
            case (funct3)
                3'b000: begin
                    if (funct12 == FUNCT12_ECALL) op_d = sys_pkg::OP_ECALL;
                    else if (funct12 == FUNCT12_MRET) op_d = sys_pkg::OP_MRET;
                end
                3'b001, 3'b101: op_d = sys_pkg::OP_CSRRW;
                3'b010, 3'b110: op_d = sys_pkg::OP_CSRRS;
                3'b011, 3'b111: op_d = sys_pkg::OP_CSRRC;
                default: op_d = sys_pkg::OP_NONE;
            endcase
        end
    end

    // funct3[2] selects the immediate forms.
    assign operand_d = funct3[2] ? sys_pkg::xlen_t'(rs1_field) : i_req.rs1_data;

    always_comb begin
        case (op_d)
            sys_pkg::OP_CSRRW: write_en_d = 1'b1;
            sys_pkg::OP_CSRRS,
            sys_pkg::OP_CSRRC: write_en_d = (rs1_field != 5'd0);
            default:           write_en_d = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) o_op.valid <= 1'b0;
        else o_op.valid <= i_req.valid && i_req.ready;
    end

    always_ff @(posedge clk) begin
        if (i_req.valid) begin
            o_op.op       <= op_d;
            o_op.csr_addr <= funct12;
            o_op.operand  <= operand_d;
            o_op.write_en <= write_en_d;
            o_op.pc       <= i_req.pc;
        end
    end

    a_op_legal: assert property (@(posedge clk) disable iff (reset)
        o_op.valid |-> o_op.op inside {sys_pkg::OP_CSRRW, sys_pkg::OP_CSRRS,
                                       sys_pkg::OP_CSRRC, sys_pkg::OP_ECALL,
                                       sys_pkg::OP_MRET, sys_pkg::OP_NONE});

endmodule

/* rtl/csr_regfile.sv */
`include "sys_config.svh"

module csr_regfile (
    input  logic           clk,
    input  logic           reset,
    sys_op_if.sink         i_op,
    output logic           o_rsp_valid,
    output sys_pkg::xlen_t o_rsp_rd_data,
    output logic           o_rsp_redirect,
    output sys_pkg::xlen_t o_rsp_target_pc,
    output logic           o_rsp_illegal
);

    // Previous privilege field of mstatus.
    localparam int MPP_LO = 11;
    localparam int MPP_HI = 12;
    localparam sys_pkg::xlen_t ECALL_CAUSE = sys_pkg::xlen_t'(11); // Ecall from M-mode.

    sys_pkg::xlen_t mstatus;
    sys_pkg::xlen_t mtvec;
    sys_pkg::xlen_t mepc;
    sys_pkg::xlen_t mcause;

    sys_pkg::xlen_t old_val;
    sys_pkg::xlen_t wr_val;
    logic           known;
    logic           is_csr_op;
    logic           csr_we;
    logic           is_ecall;
    logic           is_mret;

    // Read side. An address outside the four CSRs reads as zero.
    always_comb begin
        old_val = '0;
        known   = 1'b1;
        case (i_op.csr_addr)
            `CSR_MSTATUS: old_val = mstatus;
            `CSR_MTVEC:   old_val = mtvec;
            `CSR_MEPC:    old_val = mepc;
            `CSR_MCAUSE:  old_val = mcause;
            default:      known = 1'b0;
        endcase
    end

    always_comb begin
        case (i_op.op)
            sys_pkg::OP_CSRRW: wr_val = i_op.operand;
            sys_pkg::OP_CSRRS: wr_val = old_val | i_op.operand;
            sys_pkg::OP_CSRRC: wr_val = old_val & ~i_op.operand;
            default:           wr_val = old_val;
        endcase
    end

    assign is_csr_op = i_op.op inside {sys_pkg::OP_CSRRW, sys_pkg::OP_CSRRS,
                                       sys_pkg::OP_CSRRC};
    assign csr_we    = i_op.valid && is_csr_op && i_op.write_en && known;
    assign is_ecall  = i_op.valid && (i_op.op == sys_pkg::OP_ECALL);
    assign is_mret   = i_op.valid && (i_op.op == sys_pkg::OP_MRET);

    // Trap entry and return never coincide with a CSR write as only one op comes per cycle.
    always_ff @(posedge clk) begin
        if (reset) begin
            mstatus <= '0;
            mtvec   <= '0;
            mepc    <= '0;
            mcause  <= '0;
        end else begin
            if (csr_we) begin
                case (i_op.csr_addr)
                    `CSR_MSTATUS: mstatus <= wr_val;
                    `CSR_MTVEC:   mtvec   <= wr_val;
                    `CSR_MEPC:    mepc    <= wr_val;
                    `CSR_MCAUSE:  mcause  <= wr_val;
                    default:      mcause  <= mcause;
                endcase
            end
            if (is_ecall) begin
                mepc                    <= i_op.pc;
                mcause                  <= ECALL_CAUSE;
                mstatus[MPP_HI:MPP_LO]  <= 2'b11;
            end
            if (is_mret) mstatus[MPP_HI:MPP_LO] <= 2'b00; // Back to the lowest mode.
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            o_rsp_valid    <= 1'b0;
            o_rsp_redirect <= 1'b0;
            o_rsp_illegal  <= 1'b0;
        end else begin
            o_rsp_valid    <= i_op.valid;
            o_rsp_redirect <= is_ecall || is_mret;
            o_rsp_illegal  <= i_op.valid && is_csr_op && !known;
        end
    end

    always_ff @(posedge clk) begin
        if (i_op.valid) begin
            o_rsp_rd_data <= is_csr_op ? old_val : '0;
            // Direct mode only, so the low two bits of mtvec are dropped.
            o_rsp_target_pc <= is_ecall ? {mtvec[`XLEN-1:2], 2'b00} : mepc;
        end
    end

    // A trap or return is never reported as an illegal access.
    a_no_redirect_with_illegal: assert property (@(posedge clk) disable iff (reset)
        !(o_rsp_redirect && o_rsp_illegal));

endmodule

/* rtl/sys_unit_top.sv */
module sys_unit_top (
    input  logic           clk,
    input  logic           reset,

    input  logic           i_req_valid,
    input  sys_pkg::inst_t i_req_inst,
    input  sys_pkg::xlen_t i_req_pc,
    input  sys_pkg::xlen_t i_req_rs1_data,

    output logic           o_credit_return,

    output logic           o_rsp_valid,
    output sys_pkg::xlen_t o_rsp_rd_data,
    output logic           o_rsp_redirect,
    output sys_pkg::xlen_t o_rsp_target_pc,
    output logic           o_rsp_illegal
);

    sys_req_if req_if ();
    sys_op_if  op_if ();

    // Holds what the issue stage sent until the decoder takes it.
    sys_inst_queue i_sys_inst_queue (
        .clk             (clk),
        .reset           (reset),
        .i_valid         (i_req_valid),
        .i_inst          (i_req_inst),
        .i_pc            (i_req_pc),
        .i_rs1_data      (i_req_rs1_data),
        .o_credit_return (o_credit_return),
        .o_req           (req_if.source)
    );

    sys_decode i_sys_decode (
        .clk   (clk),
        .reset (reset),
        .i_req (req_if.sink),
        .o_op  (op_if.source)
    );

    // CSR state and the response to writeback.
    csr_regfile i_csr_regfile (
        .clk             (clk),
        .reset           (reset),
        .i_op            (op_if.sink),
        .o_rsp_valid     (o_rsp_valid),
        .o_rsp_rd_data   (o_rsp_rd_data),
        .o_rsp_redirect  (o_rsp_redirect),
        .o_rsp_target_pc (o_rsp_target_pc),
        .o_rsp_illegal   (o_rsp_illegal)
    );

endmodule

/* tests/sys_unit_tb.sv */
`include "sys_config.svh"

module sys_unit_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int DEPTH      = `SYS_QUEUE_DEPTH;
    localparam int WAIT_LIMIT = 200; // Cycles allowed for any single wait.
    localparam logic [31:0] ECALL_INST = 32'h0000_0073;
    localparam logic [31:0] MRET_INST  = 32'h3020_0073;
    localparam logic [11:0] CSR_LIST [4] = '{`CSR_MSTATUS, `CSR_MTVEC, `CSR_MEPC, `CSR_MCAUSE};

    typedef struct packed {
        logic [31:0] rd_data;
        logic        redirect;
        logic [31:0] target_pc;
        logic        illegal;
    } rsp_t;

    logic           clk = 1'b0;
    logic           reset;
    logic           i_req_valid;
    sys_pkg::inst_t i_req_inst;
    sys_pkg::xlen_t i_req_pc;
    sys_pkg::xlen_t i_req_rs1_data;
    logic           o_credit_return;
    logic           o_rsp_valid;
    sys_pkg::xlen_t o_rsp_rd_data;
    logic           o_rsp_redirect;
    sys_pkg::xlen_t o_rsp_target_pc;
    logic           o_rsp_illegal;

    logic [31:0] lfsr_state = 32'hd095;
    logic [31:0] m_mstatus = '0; // Reference copies of the four CSRs.
    logic [31:0] m_mtvec = '0;
    logic [31:0] m_mepc = '0;
    logic [31:0] m_mcause = '0;
    logic [31:0] pend_inst [$];
    logic [31:0] pend_pc [$];
    logic [31:0] pend_rs1 [$];
    rsp_t        exp_q [$];
    int          sent_count = 0;
    int          return_count = 0;
    int          rsp_count = 0;
    int          exp_total = 0;
    int          check_count = 0;
    int          error_count = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    bit          timed_out = 1'b0;

    sys_unit_top i_sys_unit_top (
        .clk             (clk),
        .reset           (reset),
        .i_req_valid     (i_req_valid),
        .i_req_inst      (i_req_inst),
        .i_req_pc        (i_req_pc),
        .i_req_rs1_data  (i_req_rs1_data),
        .o_credit_return (o_credit_return),
        .o_rsp_valid     (o_rsp_valid),
        .o_rsp_rd_data   (o_rsp_rd_data),
        .o_rsp_redirect  (o_rsp_redirect),
        .o_rsp_target_pc (o_rsp_target_pc),
        .o_rsp_illegal   (o_rsp_illegal)
    );

    always #4 clk = ~clk;

    // Credits and responses are counted away from the active edge.
    always @(negedge clk) begin
        if (!reset) begin
            if (o_credit_return) begin
                return_count++;
                if (return_count > sent_count) begin
                    error_count++;
                    $display("Credit returned with no instruction outstanding");
                end
            end
            if (o_rsp_valid) rsp_count++;
        end
    end

    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic logic [31:0] aligned_pc();
        logic [31:0] v;
        v = rand_bits(30);
        return {v[29:0], 2'b00};
    endfunction

    function automatic logic [4:0] nonzero_reg();
        return 5'(rand_bits(5)) | 5'd1;
    endfunction

    function automatic logic [31:0] csr_inst(input logic [2:0] funct3, input logic [11:0] csr,
                                             input logic [4:0] rs1);
        return {csr, rs1, funct3, 5'd1, 7'b1110011}; // rd is always x1.
    endfunction

    function automatic logic lookup_csr(input logic [11:0] csr, output logic [31:0] val);
        val = '0;
        case (csr)
            `CSR_MSTATUS: val = m_mstatus;
            `CSR_MTVEC:   val = m_mtvec;
            `CSR_MEPC:    val = m_mepc;
            `CSR_MCAUSE:  val = m_mcause;
            default:      return 1'b0;
        endcase
        return 1'b1;
    endfunction

    function automatic void store_csr(input logic [11:0] csr, input logic [31:0] val);
        case (csr)
            `CSR_MSTATUS: m_mstatus = val;
            `CSR_MTVEC:   m_mtvec = val;
            `CSR_MEPC:    m_mepc = val;
            default:      m_mcause = val;
        endcase
    endfunction

    // Applies one instruction to the reference model and records the response it expects.
    task automatic queue_inst(input logic [31:0] inst, input logic [31:0] pc,
                              input logic [31:0] rs1);
        rsp_t        rsp;
        logic [2:0]  funct3;
        logic [4:0]  rs1_field;
        logic [11:0] csr;
        logic [31:0] old_val;
        logic [31:0] operand;
        logic [31:0] new_val;
        logic        known;
        funct3 = inst[14:12];
        rs1_field = inst[19:15];
        csr = inst[31:20];
        rsp = '0;
        if (inst[6:0] == 7'b1110011 && funct3 == 3'b000 && csr == 12'h000) begin
            rsp.redirect = 1'b1;
            rsp.target_pc = {m_mtvec[31:2], 2'b00};
            m_mepc = pc;
            m_mcause = 32'd11;
            m_mstatus[12:11] = 2'b11;
        end else if (inst[6:0] == 7'b1110011 && funct3 == 3'b000 && csr == 12'h302) begin
            rsp.redirect = 1'b1;
            rsp.target_pc = m_mepc;
            m_mstatus[12:11] = 2'b00;
        end else if (inst[6:0] == 7'b1110011 && funct3[1:0] != 2'b00) begin
            known = lookup_csr(csr, old_val);
            operand = funct3[2] ? {27'd0, rs1_field} : rs1;
            rsp.rd_data = old_val;
            rsp.illegal = !known;
            case (funct3[1:0])
                2'b01:   new_val = operand;
                2'b10:   new_val = old_val | operand;
                default: new_val = old_val & ~operand;
            endcase
            if (known && (funct3[1:0] == 2'b01 || rs1_field != 5'd0)) store_csr(csr, new_val);
        end
        pend_inst.push_back(inst);
        pend_pc.push_back(pc);
        pend_rs1.push_back(rs1);
        exp_q.push_back(rsp);
    endtask

    task automatic read_back_all();
        for (int i = 0; i < 4; i++) begin
            queue_inst(csr_inst(3'b010, CSR_LIST[i], 5'd0), aligned_pc(), rand_bits(32));
        end
    endtask

    task automatic wait_credit();
        int guard;
        guard = 0;
        while (sent_count - return_count >= DEPTH && !timed_out) begin
            @(posedge clk);
            #1;
            guard++;
            if (guard >= WAIT_LIMIT) begin
                timed_out = 1'b1;
                $display("Timeout: no credit came back within %0d cycles", WAIT_LIMIT);
            end
        end
    endtask

    task automatic send_all();
        while (pend_inst.size() > 0 && !timed_out) begin
            wait_credit();
            if (!timed_out) begin
                i_req_valid = 1'b1;
                i_req_inst = pend_inst.pop_front();
                i_req_pc = pend_pc.pop_front();
                i_req_rs1_data = pend_rs1.pop_front();
                sent_count++;
                @(posedge clk);
                #1;
                i_req_valid = 1'b0;
            end
        end
    endtask

    task automatic compare_field(input string name, input string field,
                                 input logic [31:0] expected, input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Mismatch in %s: %s expected %h, actual %h", name, field, expected, actual);
        end
    endtask

    task automatic collect_responses(input string name, input int n);
        rsp_t rsp;
        int   guard;
        for (int i = 0; i < n && !timed_out; i++) begin
            guard = 0;
            while (!timed_out) begin
                @(negedge clk);
                if (o_rsp_valid) break;
                guard++;
                if (guard >= WAIT_LIMIT) begin
                    timed_out = 1'b1;
                    $display("Timeout: %s got no response within %0d cycles", name, WAIT_LIMIT);
                end
            end
            if (!timed_out && exp_q.size() > 0) begin
                rsp = exp_q.pop_front();
                compare_field(name, "rd_data", rsp.rd_data, o_rsp_rd_data);
                compare_field(name, "redirect", 32'(rsp.redirect), 32'(o_rsp_redirect));
                compare_field(name, "illegal", 32'(rsp.illegal), 32'(o_rsp_illegal));
                if (rsp.redirect) compare_field(name, "target_pc", rsp.target_pc, o_rsp_target_pc);
            end
        end
    endtask

    task automatic run_queued(input string name);
        int n;
        n = pend_inst.size();
        exp_total += n;
        fork
            send_all();
            collect_responses(name, n);
        join
        @(posedge clk);
        #1;
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (error_count == errors_before && !timed_out) begin
            tests_passed++;
            $display("PASS %s", name);
        end else begin
            tests_failed++;
            $display("FAIL %s with %0d errors", name, error_count - errors_before);
        end
    endtask

    task automatic after_reset_reads();
        int start;
        start = error_count;
        read_back_all();
        read_back_all(); // Reads with x0 must leave the CSRs as they were.
        run_queued("after_reset_reads");
        report_test("after_reset_reads", start);
    endtask

    task automatic csr_access_ops();
        int start;
        start = error_count;
        for (int i = 0; i < 4; i++) begin
            queue_inst(csr_inst(3'b001, CSR_LIST[i], nonzero_reg()), aligned_pc(), rand_bits(32));
            queue_inst(csr_inst(3'b010, CSR_LIST[i], nonzero_reg()), aligned_pc(), rand_bits(32));
            queue_inst(csr_inst(3'b011, CSR_LIST[i], nonzero_reg()), aligned_pc(), rand_bits(32));
            queue_inst(csr_inst(3'b101, CSR_LIST[i], 5'(rand_bits(5))), aligned_pc(), '0);
            queue_inst(csr_inst(3'b110, CSR_LIST[i], 5'(rand_bits(5))), aligned_pc(), '0);
            queue_inst(csr_inst(3'b111, CSR_LIST[i], 5'(rand_bits(5))), aligned_pc(), '0);
        end
        read_back_all();
        run_queued("csr_access_ops");
        report_test("csr_access_ops", start);
    endtask

    task automatic ecall_trap_entry();
        int start;
        start = error_count;
        queue_inst(csr_inst(3'b001, `CSR_MTVEC, 5'd5), aligned_pc(), rand_bits(32));
        queue_inst(ECALL_INST, aligned_pc(), rand_bits(32));
        read_back_all();
        run_queued("ecall_trap_entry");
        report_test("ecall_trap_entry", start);
    endtask

    task automatic mret_trap_return();
        int start;
        start = error_count;
        queue_inst(csr_inst(3'b001, `CSR_MEPC, 5'd6), aligned_pc(), aligned_pc());
        queue_inst(MRET_INST, aligned_pc(), rand_bits(32));
        read_back_all();
        run_queued("mret_trap_return");
        report_test("mret_trap_return", start);
    endtask

    task automatic credit_burst();
        int start;
        int sent_before;
        int returned_before;
        start = error_count;
        sent_before = sent_count;
        returned_before = return_count;
        for (int i = 0; i < 3 * DEPTH; i++) begin
            queue_inst(csr_inst(3'(i % 4 + 1), CSR_LIST[i % 4], nonzero_reg()),
                       aligned_pc(), rand_bits(32));
        end
        run_queued("credit_burst");
        compare_field("credit_burst", "credits returned", 32'(sent_count - sent_before),
                      32'(return_count - returned_before));
        report_test("credit_burst", start);
    endtask

    task automatic unknown_csr_access();
        int start;
        start = error_count;
        queue_inst(csr_inst(3'b001, 12'h7c0, nonzero_reg()), aligned_pc(), rand_bits(32));
        queue_inst(csr_inst(3'b010, 12'h344, nonzero_reg()), aligned_pc(), rand_bits(32));
        queue_inst(csr_inst(3'b111, 12'h001, 5'd31), aligned_pc(), '0);
        read_back_all();
        run_queued("unknown_csr_access");
        report_test("unknown_csr_access", start);
    endtask

    initial begin
        reset = 1'b1;
        i_req_valid = 1'b0;
        i_req_inst = '0;
        i_req_pc = '0;
        i_req_rs1_data = '0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        @(posedge clk);
        #1;
        after_reset_reads();
        csr_access_ops();
        ecall_trap_entry();
        mret_trap_return();
        credit_burst();
        unknown_csr_access();
        repeat (5) @(negedge clk); // Room for any response nobody asked for.
        compare_field("all tests", "response count", 32'(exp_total), 32'(rsp_count));
        $display("Tests passed %0d, failed %0d, checks %0d, errors %0d",
                 tests_passed, tests_failed, check_count, error_count);
        if (error_count == 0 && !timed_out) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+include
rtl/sys_pkg.sv
rtl/sys_req_if.sv
rtl/sys_inst_queue.sv
rtl/sys_decode.sv
rtl/csr_regfile.sv
rtl/sys_unit_top.sv
tests/sys_unit_tb.sv

/* Makefile */
# Verilator build and run of the system unit testbench.
# Any variable below can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= sys_unit_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/100ps
VFLAGS    ?=

VERILATOR_FLAGS = --binary --timing --assert --timescale $(TIMESCALE) \
                  --top-module $(TOP) -Mdir $(BUILD_DIR)

.PHONY: sim clean

# The run fails when the log holds the fail text or the binary exits with an error.
sim:
	$(VERILATOR) $(VERILATOR_FLAGS) $(VFLAGS) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Simulation failed" $(LOG); then \
		echo "FAIL: see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
